//--- build.f
+incdir+rtl
rtl/qspi_pkg.sv
rtl/qspi_1r1w.sv
rtl/qspi_psram_model.sv
rtl/qspi_host_ctrl.sv
rtl/qspi_psram_sys.sv
dv/qspi_psram_sys_tb.sv

//--- dv/qspi_psram_sys_tb.sv
`include "qspi_defs.svh"

module qspi_psram_sys_tb;
	import qspi_pkg::*;

	localparam int TIMEOUT = 2000;
	localparam int NUM_RANDOM = 40;

	logic clk;
	logic rst_n;
	logic start;
	host_op_t op;
	logic [`QSPI_ADR_W-1:0] addr;
	logic [7:0] wdata;
	logic busy;
	logic done;
	logic [7:0] rdata;

	int errors;
	int checks;

	// expected memory contents, only for bytes that were written
	logic [7:0] shadow [0:(1 << `QSPI_ADR_W) - 1];
	logic [`QSPI_ADR_W-1:0] written [$];

	// rdata as seen in the done cycle
	logic [7:0] done_rdata;

	qspi_psram_sys qspi_psram_sys_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.op    (op),
		.addr  (addr),
		.wdata (wdata),
		.busy  (busy),
		.done  (done),
		.rdata (rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// one-cycle start, then busy should be up
	task automatic pulse_start(input host_op_t o, input logic [`QSPI_ADR_W-1:0] a,
			input logic [7:0] d);
		@(posedge clk);
		start <= 1'b1;
		op <= o;
		addr <= a;
		wdata <= d;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		checks++;
		assert (busy === 1'b1) else begin
			errors++;
			$display("Fail %0t: busy did not rise after start", $time);
		end
	endtask

	// ends on the negedge after done
	task automatic wait_done();
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (done === 1'b1) begin
				seen = 1'b1;
				// read data must already be valid with done
				done_rdata = rdata;
			end
		end
		if (!seen) begin
			errors++;
			$display("Timeout: done never arrived within %0d cycles, time %0t", TIMEOUT, $time);
		end else begin
			@(negedge clk);
			checks++;
			assert (done === 1'b0 && busy === 1'b0) else begin
				errors++;
				$display("Fail %0t: done not a single pulse or busy still high", $time);
			end
		end
	endtask

	task automatic do_write(input logic [`QSPI_ADR_W-1:0] a, input logic [7:0] d);
		pulse_start(OP_WRITE, a, d);
		wait_done();
		shadow[a] = d;
		written.push_back(a);
	endtask

	task automatic do_read(input logic [`QSPI_ADR_W-1:0] a, output logic [7:0] d);
		pulse_start(OP_READ, a, 8'h00);
		wait_done();
		d = done_rdata;
	endtask

	task automatic do_reset();
		pulse_start(OP_RESET, '0, 8'h00);
		wait_done();
	endtask

	task automatic check_read(input logic [`QSPI_ADR_W-1:0] a);
		logic [7:0] got;
		do_read(a, got);
		checks++;
		assert (got === shadow[a]) else begin
			errors++;
			$display("Fail %0t: addr 0x%04h read 0x%02h, expected 0x%02h",
				$time, a, got, shadow[a]);
		end
	endtask

	task automatic check_idle_after_reset();
		logic [7:0] unused;
		@(negedge clk);
		checks++;
		assert (busy === 1'b0 && done === 1'b0 && rdata === 8'h00) else begin
			errors++;
			$display("Fail %0t: outputs not idle after reset", $time);
		end
		// address never written, data not compared
		do_read(16'hfff0, unused);
	endtask

	task automatic write_then_read();
		do_write(16'h0042, 8'h5a);
		check_read(16'h0042);
	endtask

	task automatic random_fill_readback();
		logic [`QSPI_ADR_W-1:0] addrs [$];
		logic [`QSPI_ADR_W-1:0] a;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			a = `QSPI_ADR_W'($urandom);
			do_write(a, 8'($urandom));
			addrs.push_back(a);
		end
		// read back newest first
		for (int i = NUM_RANDOM - 1; i >= 0; i--) begin
			check_read(addrs[i]);
		end
	endtask

	// neighbours share the nibble memory
	task automatic adjacent_bytes();
		do_write(16'h1230, 8'ha5);
		do_write(16'h1231, 8'h3c);
		do_write(16'h122f, 8'h81);
		check_read(16'h1230);
		check_read(16'h1231);
		check_read(16'h122f);
		do_write(16'h1231, 8'hf0);
		check_read(16'h1230);
		check_read(16'h1231);
	endtask

	task automatic reset_keeps_memory();
		do_reset();
		foreach (written[i]) begin
			check_read(written[i]);
		end
	endtask

	task automatic start_while_busy();
		int extra;
		logic [`QSPI_ADR_W-1:0] a;
		logic [`QSPI_ADR_W-1:0] b;
		a = 16'h1230;
		b = 16'h0042;
		extra = 0;
		pulse_start(OP_READ, a, 8'h00);
		repeat (20) @(posedge clk);
		start <= 1'b1;
		op <= OP_WRITE;
		addr <= b;
		wdata <= ~shadow[b];
		@(posedge clk);
		start <= 1'b0;
		wait_done();
		checks++;
		assert (done_rdata === shadow[a]) else begin
			errors++;
			$display("Fail %0t: read under second start got 0x%02h, expected 0x%02h",
				$time, done_rdata, shadow[a]);
		end
		// the ignored write must never start
		for (int i = 0; i < 400; i++) begin
			@(negedge clk);
			if (done === 1'b1 || busy === 1'b1) begin
				extra++;
			end
		end
		checks++;
		assert (extra == 0) else begin
			errors++;
			$display("Fail %0t: activity after done, %0d cycles", $time, extra);
		end
		check_read(b);
	endtask

	initial begin
		int unsigned seed;
		seed = $urandom(53);
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		start = 1'b0;
		op = OP_READ;
		addr = '0;
		wdata = 8'h00;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		check_idle_after_reset();
		write_then_read();
		random_fill_readback();
		adjacent_bytes();
		reset_keeps_memory();
		start_while_busy();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/qspi_psram_sys.sv
`include "qspi_defs.svh"

module qspi_psram_sys (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  qspi_pkg::host_op_t     op,
	input  logic [`QSPI_ADR_W-1:0] addr,
	input  logic [7:0]             wdata,
	output logic                   busy,
	output logic                   done,
	output logic [7:0]             rdata
);

	// serial lines between controller and device
	logic sck;
	logic ce_n;
	logic [3:0] sio_i;
	logic [3:0] sio_o;
	logic sio_oe;

	qspi_host_ctrl qspi_host_ctrl_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.op     (op),
		.addr   (addr),
		.wdata  (wdata),
		.sio_o  (sio_o),
		.sio_oe (sio_oe),
		.busy   (busy),
		.done   (done),
		.rdata  (rdata),
		.sck    (sck),
		.ce_n   (ce_n),
		.sio_i  (sio_i)
	);

	qspi_psram_model qspi_psram_model_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.sck    (sck),
		.ce_n   (ce_n),
		.sio_i  (sio_i),
		.sio_o  (sio_o),
		.sio_oe (sio_oe)
	);

endmodule

//--- rtl/qspi_host_ctrl.sv
`include "qspi_defs.svh"

module qspi_host_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  qspi_pkg::host_op_t     op,
	input  logic [`QSPI_ADR_W-1:0] addr,
	input  logic [7:0]             wdata,
	input  logic [3:0]             sio_o,
	input  logic                   sio_oe,
	output logic                   busy,
	output logic                   done,
	output logic [7:0]             rdata,
	output logic                   sck,
	output logic                   ce_n,
	output logic [3:0]             sio_i
);
	import qspi_pkg::*;

	localparam int SR_W = 4 * `QSPI_ADR_NIBBLES;
	localparam int DIV_W = $clog2(`QSPI_SCK_HALF + 1);
	localparam int CNT_W = 5;
	localparam int DATA_NIBBLES = 2;
	// four half periods deselected, then one with ce_n low before sck moves
	localparam int GUARD = 5;

	host_state_t state;
	logic [DIV_W-1:0] div_cnt;
	logic half_tick;
	logic [CNT_W-1:0] edge_cnt;
	logic last_edge;
	logic [SR_W-1:0] sreg;
	qspi_cmd_t cur_cmd;
	host_op_t op_q;
	logic [`QSPI_ADR_W-1:0] addr_q;
	logic [7:0] wdata_q;
	logic [7:0] rd_sr;
	logic [3:0] nib_in;

	function automatic qspi_cmd_t op_cmd(input host_op_t o);
		case (o)
			OP_WRITE: op_cmd = CMD_QWRITE;
			OP_RESET: op_cmd = CMD_RST_EN;
			default:  op_cmd = CMD_FREADQ;
		endcase
	endfunction

	// sck half period divider
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (state == HS_IDLE || half_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign half_tick = (div_cnt == DIV_W'(`QSPI_SCK_HALF - 1));
	assign last_edge = (edge_cnt == CNT_W'(1));
	assign nib_in = sio_oe ? sio_o : 4'h0;

	assign busy = (state != HS_IDLE);
	assign done = (state == HS_DONE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= HS_IDLE;
			edge_cnt <= '0;
			sreg <= '0;
			cur_cmd <= CMD_FREADQ;
			op_q <= OP_READ;
			addr_q <= '0;
			wdata_q <= 8'h00;
			rd_sr <= 8'h00;
			rdata <= 8'h00;
			sck <= 1'b1;
			ce_n <= 1'b1;
			sio_i <= 4'h0;
		end else begin
			case (state)
				HS_IDLE: begin
					if (start) begin
						op_q <= op;
						addr_q <= addr;
						wdata_q <= wdata;
						cur_cmd <= op_cmd(op);
						sreg <= {op_cmd(op), {(SR_W - 8){1'b0}}};
						rd_sr <= 8'h00;
						edge_cnt <= CNT_W'(GUARD);
						state <= HS_SELECT;
					end
				end
				HS_SELECT: begin
					if (half_tick) begin
						if (edge_cnt == CNT_W'(2)) begin
							ce_n <= 1'b0;
						end
						if (last_edge) begin
							edge_cnt <= CNT_W'(`QSPI_CMD_BITS);
							state <= HS_CMD;
						end else begin
							edge_cnt <= edge_cnt - 1'b1;
						end
					end
				end
				HS_CMD, HS_ADR, HS_WAIT, HS_DATA, HS_RST: begin
					if (half_tick && sck) begin
						// falling sck, put out the next bit or nibble
						sck <= 1'b0;
						if (state == HS_CMD) begin
							sio_i <= {3'b000, sreg[SR_W-1]};
							sreg <= sreg << 1;
						end else if (state == HS_ADR ||
								(state == HS_DATA && op_q == OP_WRITE)) begin
							sio_i <= sreg[SR_W-1 -: 4];
							sreg <= sreg << 4;
						end else begin
							sio_i <= 4'h0;
						end
					end else if (half_tick) begin
						sck <= 1'b1;
						edge_cnt <= edge_cnt - 1'b1;
						// sample read data on the cycle sck goes high
						if (state == HS_DATA && op_q == OP_READ) begin
							rd_sr <= {rd_sr[3:0], nib_in};
						end
						if (last_edge) begin
							case (state)
								HS_CMD: begin
									if (cur_cmd == CMD_FREADQ || cur_cmd == CMD_QWRITE) begin
										sreg <= {{(SR_W - `QSPI_ADR_W){1'b0}}, addr_q};
										edge_cnt <= CNT_W'(`QSPI_ADR_NIBBLES);
										state <= HS_ADR;
									end else begin
										edge_cnt <= CNT_W'(`QSPI_RST_CLKS);
										state <= HS_RST;
									end
								end
								HS_ADR: begin
									if (op_q == OP_WRITE) begin
										sreg <= {wdata_q, {(SR_W - 8){1'b0}}};
										edge_cnt <= CNT_W'(DATA_NIBBLES);
										state <= HS_DATA;
									end else begin
										edge_cnt <= CNT_W'(`QSPI_RD_WAIT);
										state <= HS_WAIT;
									end
								end
								HS_WAIT: begin
									edge_cnt <= CNT_W'(DATA_NIBBLES);
									state <= HS_DATA;
								end
								HS_RST: begin
									// reset-enable done, follow with the reset opcode
									if (cur_cmd == CMD_RST_EN) begin
										cur_cmd <= CMD_RESET;
										sreg <= {CMD_RESET, {(SR_W - 8){1'b0}}};
										edge_cnt <= CNT_W'(`QSPI_CMD_BITS);
										state <= HS_CMD;
									end else begin
										state <= HS_DESEL;
									end
								end
								default: state <= HS_DESEL;
							endcase
						end
					end
				end
				HS_DESEL: begin
					// hold ce_n low for half a period after the last edge
					if (ce_n) begin
						// read data goes out together with done
						if (op_q == OP_READ) begin
							rdata <= rd_sr;
						end
						state <= HS_DONE;
					end else if (half_tick) begin
						ce_n <= 1'b1;
						sio_i <= 4'h0;
					end
				end
				HS_DONE: begin
					state <= HS_IDLE;
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

endmodule

//--- rtl/qspi_psram_model.sv
`include "qspi_defs.svh"

module qspi_psram_model (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       sck,
	input  logic       ce_n,
	input  logic [3:0] sio_i,
	output logic [3:0] sio_o,
	output logic       sio_oe
);
	import qspi_pkg::*;

	logic sck_m;
	logic sck_s;
	logic sck_d;
	logic ce_n_m;
	logic ce_n_s;
	logic [3:0] sio_m;
	logic [3:0] sio_s;
	logic rise_edge;
	logic step;
	logic enter;
	logic reset_done;

	psram_state_t state;
	psram_state_t state_nxt;

	logic [7:0] cmd_sr;
	logic [7:0] cmd_nxt;
	logic [3:0] cmd_cnt;
	logic [`QSPI_ADR_W-1:0] adr_sr;
	logic [`QSPI_ADR_W-1:0] adr_nxt;
	logic [3:0] adr_cnt;
	logic [3:0] wait_cnt;
	logic [4:0] rst_cnt;

	logic [`QSPI_ADR_W-1:0] wr_byte;
	logic wr_half;
	logic [`QSPI_ADR_W-1:0] rd_byte;
	logic rd_half;
	logic ram_wen;

	// two flops on every serial input, sck gets a third for edge detect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_m <= 1'b1;
			sck_s <= 1'b1;
			sck_d <= 1'b1;
			ce_n_m <= 1'b1;
			ce_n_s <= 1'b1;
			sio_m <= 4'h0;
			sio_s <= 4'h0;
		end else begin
			sck_m <= sck;
			sck_s <= sck_m;
			sck_d <= sck_s;
			ce_n_m <= ce_n;
			ce_n_s <= ce_n_m;
			sio_m <= sio_i;
			sio_s <= sio_m;
		end
	end

	assign rise_edge = sck_s & ~sck_d;
	assign step = rise_edge & ~ce_n_s;
	assign enter = step && (state_nxt != state);
	assign reset_done = step && (state == MN_RESET) && (rst_cnt == 5'd1);

	assign cmd_nxt = {cmd_sr[6:0], sio_s[0]};
	assign adr_nxt = {adr_sr[`QSPI_ADR_W-5:0], sio_s};

	// each counter holds the edges left in its phase, 1 marks the last
	always_comb begin
		state_nxt = state;
		case (state)
			MN_IDLE: state_nxt = MN_CMD;
			MN_CMD: begin
				if (cmd_cnt == 4'd1) begin
					case (cmd_nxt)
						CMD_FREADQ, CMD_QWRITE: state_nxt = MN_ADR;
						CMD_RST_EN: state_nxt = MN_RSTEN;
						default: state_nxt = MN_IDLE;
					endcase
				end
			end
			MN_ADR: begin
				if (adr_cnt == 4'd1) begin
					state_nxt = (cmd_sr == CMD_QWRITE) ? MN_WTDAT : MN_RDWIT;
				end
			end
			MN_RDWIT: begin
				if (wait_cnt == 4'd1) begin
					state_nxt = MN_RDDAT;
				end
			end
			MN_WTDAT, MN_RDDAT: state_nxt = state;
			MN_RSTEN: begin
				if (rst_cnt == 5'd1) begin
					state_nxt = MN_RESET;
				end
			end
			MN_RESET: begin
				if (rst_cnt == 5'd1) begin
					state_nxt = MN_IDLE;
				end
			end
			default: state_nxt = MN_IDLE;
		endcase
	end

	// deselect ends any transaction at once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= MN_IDLE;
		end else if (ce_n_s) begin
			state <= MN_IDLE;
		end else if (rise_edge) begin
			state <= state_nxt;
		end
	end

	// command shifter, first bit arrives while still idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_sr <= 8'h00;
			cmd_cnt <= 4'd0;
		end else begin
			if (reset_done) begin
				cmd_sr <= 8'h00;
			end else if (step && state == MN_IDLE) begin
				cmd_sr <= {7'd0, sio_s[0]};
			end else if (step && state == MN_CMD) begin
				cmd_sr <= cmd_nxt;
			end
			if (enter && state_nxt == MN_CMD) begin
				cmd_cnt <= 4'(`QSPI_CMD_BITS - 1);
			end else if (step && state == MN_CMD) begin
				cmd_cnt <= cmd_cnt - 4'd1;
			end
		end
	end

	// address shifter keeps the low byte address bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			adr_sr <= '0;
			adr_cnt <= 4'd0;
		end else if (reset_done) begin
			adr_sr <= '0;
		end else if (enter && state_nxt == MN_ADR) begin
			adr_sr <= '0;
			adr_cnt <= 4'(`QSPI_ADR_NIBBLES);
		end else if (step && state == MN_ADR) begin
			adr_sr <= adr_nxt;
			adr_cnt <= adr_cnt - 4'd1;
		end
	end

	// dummy cycles before read data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= 4'd0;
		end else if (enter && state_nxt == MN_RDWIT) begin
			wait_cnt <= 4'(`QSPI_RD_WAIT);
		end else if (step && state == MN_RDWIT) begin
			wait_cnt <= wait_cnt - 4'd1;
		end
	end

	// reset phase also swallows the reset opcode bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rst_cnt <= 5'd0;
		end else if (enter && state_nxt == MN_RSTEN) begin
			rst_cnt <= 5'(`QSPI_RST_CLKS);
		end else if (enter && state_nxt == MN_RESET) begin
			rst_cnt <= 5'(`QSPI_CMD_BITS + `QSPI_RST_CLKS);
		end else if (step && (state == MN_RSTEN || state == MN_RESET)) begin
			rst_cnt <= rst_cnt - 5'd1;
		end
	end

	// write nibble pointer, high nibble first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_byte <= '0;
			wr_half <= 1'b1;
		end else if (reset_done) begin
			wr_byte <= '0;
			wr_half <= 1'b1;
		end else if (enter && state_nxt == MN_WTDAT) begin
			wr_byte <= adr_nxt;
			wr_half <= 1'b1;
		end else if (step && state == MN_WTDAT) begin
			wr_half <= ~wr_half;
			if (!wr_half) begin
				wr_byte <= wr_byte + 1'b1;
			end
		end
	end

	// read pointer is loaded when the wait phase starts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_byte <= '0;
			rd_half <= 1'b1;
		end else if (reset_done) begin
			rd_byte <= '0;
			rd_half <= 1'b1;
		end else if (enter && state_nxt == MN_RDWIT) begin
			rd_byte <= adr_nxt;
			rd_half <= 1'b1;
		end else if (step && state == MN_RDDAT) begin
			rd_half <= ~rd_half;
			if (!rd_half) begin
				rd_byte <= rd_byte + 1'b1;
			end
		end
	end

	assign ram_wen = step && (state == MN_WTDAT);
	assign sio_oe = (state == MN_RDDAT) && !ce_n_s;

	qspi_1r1w qspi_1r1w_inst (
		.clk       (clk),
		.ram_radr  ({rd_byte, rd_half}),
		.ram_rdata (sio_o),
		.ram_wadr  ({wr_byte, wr_half}),
		.ram_wdata (sio_s),
		.ram_wen   (ram_wen)
	);

endmodule

//--- rtl/qspi_1r1w.sv
`include "qspi_defs.svh"

module qspi_1r1w (
	input  logic                    clk,
	input  logic [`QSPI_MEM_AW-1:0] ram_radr,
	output logic [3:0]              ram_rdata,
	input  logic [`QSPI_MEM_AW-1:0] ram_wadr,
	input  logic [3:0]              ram_wdata,
	input  logic                    ram_wen
);

	// one nibble per entry
	logic [3:0] mem [0:(1 << `QSPI_MEM_AW) - 1];

	always_ff @(posedge clk) begin
		if (ram_wen) begin
			mem[ram_wadr] <= ram_wdata;
		end
	end

	// read port has no clock
	assign ram_rdata = mem[ram_radr];

endmodule

//--- rtl/qspi_pkg.sv
package qspi_pkg;

	// device command opcodes
	typedef enum logic [7:0] {
		CMD_FREADQ = 8'hEB,
		CMD_QWRITE = 8'h38,
		CMD_RST_EN = 8'h66,
		CMD_RESET  = 8'h99
	} qspi_cmd_t;

	// device model states
	typedef enum logic [3:0] {
		MN_IDLE  = 4'b0000,
		MN_CMD   = 4'b0001,
		MN_ADR   = 4'b0010,
		MN_WTDAT = 4'b0011,
		MN_RDWIT = 4'b0101,
		MN_RDDAT = 4'b0111,
		MN_RSTEN = 4'b1000,
		MN_RESET = 4'b1001
	} psram_state_t;

	// host controller states
	typedef enum logic [3:0] {
		HS_IDLE,
		HS_SELECT,
		HS_CMD,
		HS_ADR,
		HS_WAIT,
		HS_DATA,
		HS_RST,
		HS_DESEL,
		HS_DONE
	} host_state_t;

	// operations a host can request
	typedef enum logic [1:0] {
		OP_READ  = 2'd0,
		OP_WRITE = 2'd1,
		OP_RESET = 2'd2
	} host_op_t;

endpackage

//--- rtl/qspi_defs.svh
`ifndef QSPI_DEFS_SVH
`define QSPI_DEFS_SVH

// byte address seen by host and model
`define QSPI_ADR_W 16

// nibble memory address, byte address plus half-byte select
`define QSPI_MEM_AW 17

// serial clocks per phase
`define QSPI_CMD_BITS 8
`define QSPI_ADR_NIBBLES 6
`define QSPI_RD_WAIT 6

// clk cycles per sck half period
`define QSPI_SCK_HALF 4

// serial clocks held in each reset phase
`define QSPI_RST_CLKS 10

`endif
